//--- rtl/pkt_assemble.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_assemble (
  input  logic                   clock,
  input  logic                   rst_n_i,

  input  logic                   req_valid_i,
  input  usb_pkt_pkg::req_kind_t req_kind_i,
  input  usb_pkt_pkg::pid_t      req_pid_i,
  input  logic [15:0]            req_field_i,
  input  logic                   req_zero_i,

  input  logic                   dat_valid_i,
  input  usb_pkt_pkg::usb_byte_t dat_data_i,
  input  logic                   dat_last_i,
  input  logic                   stage_ready_i,

  output logic                   req_done_o,
  output logic                   dat_ready_o,
  output logic                   stage_valid_o,
  output usb_pkt_pkg::usb_byte_t stage_data_o,
  output logic                   stage_last_o
);

  typedef enum logic [2:0] {
    PH_PID,
    PH_FIELD_LO,
    PH_FIELD_HI,
    PH_PAYLOAD,
    PH_CRC_LO,
    PH_CRC_HI,
    PH_DONE
  } phase_t;

  phase_t      phase_q;
  phase_t      phase_d;
  logic [15:0] crc_q;
  logic        fire;
  logic        pay_fire;

  assign fire     = stage_valid_o && stage_ready_i;
  assign pay_fire = (phase_q == PH_PAYLOAD) && dat_valid_i && stage_ready_i;

  always_comb begin
    phase_d       = phase_q;
    stage_valid_o = 1'b0;
    stage_data_o  = 8'h00;
    stage_last_o  = 1'b0;
    dat_ready_o   = 1'b0;
    req_done_o    = 1'b0;
    case (phase_q)
      // Waiting phase doubles as the PID slot, offered as soon as a request is up
      PH_PID: begin
        stage_valid_o = req_valid_i;
        stage_data_o  = {~req_pid_i, req_pid_i};
        stage_last_o  = (req_kind_i == usb_pkt_pkg::REQ_HSK);
        if (fire) begin
          case (req_kind_i)
            usb_pkt_pkg::REQ_HSK:   phase_d = PH_DONE;
            usb_pkt_pkg::REQ_TOKEN: phase_d = PH_FIELD_LO;
            default:                phase_d = req_zero_i ? PH_CRC_LO : PH_PAYLOAD;
          endcase
        end
      end
      PH_FIELD_LO: begin
        stage_valid_o = 1'b1;
        stage_data_o  = req_field_i[7:0];
        if (fire) phase_d = PH_FIELD_HI;
      end
      PH_FIELD_HI: begin
        stage_valid_o = 1'b1;
        stage_data_o  = req_field_i[15:8];
        stage_last_o  = 1'b1;
        if (fire) phase_d = PH_DONE;
      end
      // Payload passes straight through, stalls follow dat_valid_i
      PH_PAYLOAD: begin
        stage_valid_o = dat_valid_i;
        stage_data_o  = dat_data_i;
        dat_ready_o   = stage_ready_i;
        if (pay_fire && dat_last_i) phase_d = PH_CRC_LO;
      end
      PH_CRC_LO: begin
        stage_valid_o = 1'b1;
        stage_data_o  = ~crc_q[7:0];
        if (fire) phase_d = PH_CRC_HI;
      end
      PH_CRC_HI: begin
        stage_valid_o = 1'b1;
        stage_data_o  = ~crc_q[15:8];
        stage_last_o  = 1'b1;
        if (fire) phase_d = PH_DONE;
      end
      // Done once the output stage has released the final byte
      PH_DONE: begin
        req_done_o = stage_ready_i;
        if (stage_ready_i) phase_d = PH_PID;
      end
      default: phase_d = PH_PID;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      phase_q <= PH_PID;
    end else begin
      phase_q <= phase_d;
    end
  end

  // CRC16 restarts while waiting and runs over accepted payload bytes
  always_ff @(posedge clock) begin
    if (phase_q == PH_PID) begin
      crc_q <= 16'hffff;
    end else if (pay_fire) begin
      crc_q <= usb_pkt_pkg::crc16_step(crc_q, dat_data_i);
    end
  end

endmodule

`default_nettype wire

//--- rtl/pkt_request_select.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_request_select (
  input  logic                   clock,
  input  logic                   rst_n_i,

  input  logic                   tok_send_i,
  input  usb_pkt_pkg::tok_kind_t tok_kind_i,
  input  usb_pkt_pkg::usb_addr_t tok_addr_i,
  input  usb_pkt_pkg::usb_endp_t tok_endp_i,
  input  logic                   hsk_send_i,
  input  usb_pkt_pkg::hsk_kind_t hsk_kind_i,
  input  logic                   dat_send_i,
  input  logic                   dat_odd_i,
  input  logic                   dat_zero_i,
  input  logic                   req_done_i,

  output logic                   req_valid_o,
  output usb_pkt_pkg::req_kind_t req_kind_o,
  output usb_pkt_pkg::pid_t      req_pid_o,
  output logic [15:0]            req_field_o,
  output logic                   req_zero_o,
  output logic                   busy_o,
  output logic                   pkt_done_o
);

  logic                   req_valid_q;
  logic                   deaf_q;
  usb_pkt_pkg::req_kind_t kind_q;
  usb_pkt_pkg::pid_t      pid_q;
  logic [15:0]            field_q;
  logic                   zero_q;
  logic                   idle;
  logic                   any_send;

  assign idle     = !req_valid_q && !deaf_q;
  assign any_send = hsk_send_i || tok_send_i || dat_send_i;

  // Request held until done, then one cycle deaf so the strobe can drop
  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      req_valid_q <= 1'b0;
      deaf_q      <= 1'b0;
      kind_q      <= usb_pkt_pkg::REQ_HSK;
    end else begin
      deaf_q <= req_valid_q && req_done_i;
      if (idle && any_send) begin
        req_valid_q <= 1'b1;
        if (hsk_send_i) kind_q <= usb_pkt_pkg::REQ_HSK;
        else if (tok_send_i) kind_q <= usb_pkt_pkg::REQ_TOKEN;
        else kind_q <= usb_pkt_pkg::REQ_DATA;
      end else if (req_done_i) begin
        req_valid_q <= 1'b0;
      end
    end
  end

  // Fields of the winner, priority handshake then token then data
  always_ff @(posedge clock) begin
    if (idle) begin
      if (hsk_send_i) begin
        pid_q   <= (hsk_kind_i == usb_pkt_pkg::HSK_NAK) ? usb_pkt_pkg::PID_NAK
                                                         : usb_pkt_pkg::PID_ACK;
        field_q <= 16'h0000;
        zero_q  <= 1'b0;
      end else if (tok_send_i) begin
        pid_q   <= usb_pkt_pkg::tok_pid(tok_kind_i);
        field_q <= {usb_pkt_pkg::crc5_calc({tok_endp_i, tok_addr_i}), tok_endp_i, tok_addr_i};
        zero_q  <= 1'b0;
      end else if (dat_send_i) begin
        pid_q   <= dat_odd_i ? usb_pkt_pkg::PID_DATA1 : usb_pkt_pkg::PID_DATA0;
        field_q <= 16'h0000;
        zero_q  <= dat_zero_i;
      end
    end
  end

  assign req_valid_o = req_valid_q;
  assign req_kind_o  = kind_q;
  assign req_pid_o   = pid_q;
  assign req_field_o = field_q;
  assign req_zero_o  = zero_q;
  assign busy_o      = req_valid_q;
  assign pkt_done_o  = req_done_i;

endmodule

`default_nettype wire

//--- rtl/tx_byte_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tx_byte_stage (
  input  logic                   clock,
  input  logic                   rst_n_i,

  input  logic                   stage_valid_i,
  input  usb_pkt_pkg::usb_byte_t stage_data_i,
  input  logic                   stage_last_i,
  input  logic                   tx_ready_i,

  output logic                   stage_ready_o,
  output logic                   tx_valid_o,
  output usb_pkt_pkg::usb_byte_t tx_data_o,
  output logic                   tx_last_o
);

  logic                   valid_q;
  usb_pkt_pkg::usb_byte_t data_q;
  logic                   last_q;

  // Free when empty or when the held byte leaves this cycle
  assign stage_ready_o = !valid_q || tx_ready_i;

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (stage_ready_o) begin
      valid_q <= stage_valid_i;
    end
  end

  always_ff @(posedge clock) begin
    if (stage_valid_i && stage_ready_o) begin
      data_q <= stage_data_i;
      last_q <= stage_last_i;
    end
  end

  assign tx_valid_o = valid_q;
  assign tx_data_o  = data_q;
  assign tx_last_o  = last_q;

endmodule

`default_nettype wire

//--- rtl/usb_host_pkt_tx.sv
`timescale 1ns/1ps
`default_nettype none

module usb_host_pkt_tx (
  input  logic                   clock,
  input  logic                   rst_n_i,

  // Token, handshake and data requests
  input  logic                   tok_send_i,
  input  usb_pkt_pkg::tok_kind_t tok_kind_i,
  input  usb_pkt_pkg::usb_addr_t tok_addr_i,
  input  usb_pkt_pkg::usb_endp_t tok_endp_i,
  input  logic                   hsk_send_i,
  input  usb_pkt_pkg::hsk_kind_t hsk_kind_i,
  input  logic                   dat_send_i,
  input  logic                   dat_odd_i,
  input  logic                   dat_zero_i,

  // Payload stream
  input  logic                   dat_valid_i,
  input  usb_pkt_pkg::usb_byte_t dat_data_i,
  input  logic                   dat_last_i,
  output logic                   dat_ready_o,

  // Byte stream toward the ULPI PHY
  output logic                   tx_valid_o,
  output usb_pkt_pkg::usb_byte_t tx_data_o,
  output logic                   tx_last_o,
  input  logic                   tx_ready_i,

  output logic                   busy_o,
  output logic                   pkt_done_o
);

  logic                   req_valid;
  usb_pkt_pkg::req_kind_t req_kind;
  usb_pkt_pkg::pid_t      req_pid;
  logic [15:0]            req_field;
  logic                   req_zero;
  logic                   req_done;
  logic                   stage_valid;
  usb_pkt_pkg::usb_byte_t stage_data;
  logic                   stage_last;
  logic                   stage_ready;

  pkt_request_select u_request_select (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .tok_send_i  (tok_send_i),
    .tok_kind_i  (tok_kind_i),
    .tok_addr_i  (tok_addr_i),
    .tok_endp_i  (tok_endp_i),
    .hsk_send_i  (hsk_send_i),
    .hsk_kind_i  (hsk_kind_i),
    .dat_send_i  (dat_send_i),
    .dat_odd_i   (dat_odd_i),
    .dat_zero_i  (dat_zero_i),
    .req_done_i  (req_done),
    .req_valid_o (req_valid),
    .req_kind_o  (req_kind),
    .req_pid_o   (req_pid),
    .req_field_o (req_field),
    .req_zero_o  (req_zero),
    .busy_o      (busy_o),
    .pkt_done_o  (pkt_done_o)
  );

  pkt_assemble u_assemble (
    .clock         (clock),
    .rst_n_i       (rst_n_i),
    .req_valid_i   (req_valid),
    .req_kind_i    (req_kind),
    .req_pid_i     (req_pid),
    .req_field_i   (req_field),
    .req_zero_i    (req_zero),
    .dat_valid_i   (dat_valid_i),
    .dat_data_i    (dat_data_i),
    .dat_last_i    (dat_last_i),
    .stage_ready_i (stage_ready),
    .req_done_o    (req_done),
    .dat_ready_o   (dat_ready_o),
    .stage_valid_o (stage_valid),
    .stage_data_o  (stage_data),
    .stage_last_o  (stage_last)
  );

  tx_byte_stage u_byte_stage (
    .clock         (clock),
    .rst_n_i       (rst_n_i),
    .stage_valid_i (stage_valid),
    .stage_data_i  (stage_data),
    .stage_last_i  (stage_last),
    .tx_ready_i    (tx_ready_i),
    .stage_ready_o (stage_ready),
    .tx_valid_o    (tx_valid_o),
    .tx_data_o     (tx_data_o),
    .tx_last_o     (tx_last_o)
  );

endmodule

`default_nettype wire

//--- rtl/usb_pkt_pkg.sv
`default_nettype none

package usb_pkt_pkg;

  typedef logic [3:0] pid_t;
  typedef logic [6:0] usb_addr_t;
  typedef logic [3:0] usb_endp_t;
  typedef logic [7:0] usb_byte_t;

  // Packet identifiers, low nibble of the PID byte
  localparam pid_t PID_OUT   = 4'b0001;
  localparam pid_t PID_IN    = 4'b1001;
  localparam pid_t PID_SOF   = 4'b0101;
  localparam pid_t PID_SETUP = 4'b1101;
  localparam pid_t PID_ACK   = 4'b0010;
  localparam pid_t PID_NAK   = 4'b1010;
  localparam pid_t PID_DATA0 = 4'b0011;
  localparam pid_t PID_DATA1 = 4'b1011;

  typedef enum logic [1:0] {
    TOK_OUT   = 2'd0,
    TOK_SOF   = 2'd1,
    TOK_IN    = 2'd2,
    TOK_SETUP = 2'd3
  } tok_kind_t;

  typedef enum logic {
    HSK_ACK = 1'b0,
    HSK_NAK = 1'b1
  } hsk_kind_t;

  // Packet shape produced by the assembler
  typedef enum logic [1:0] {
    REQ_TOKEN,
    REQ_HSK,
    REQ_DATA
  } req_kind_t;

  localparam logic [4:0]  CRC5_POLY    = 5'b00101;
  localparam logic [15:0] CRC16_POLY_R = 16'ha001;

  function automatic pid_t tok_pid(input tok_kind_t kind);
    case (kind)
      TOK_OUT: return PID_OUT;
      TOK_SOF: return PID_SOF;
      TOK_IN:  return PID_IN;
      default: return PID_SETUP;
    endcase
  endfunction

  // CRC5 over address and endpoint, LSB first
  // Returned bit-reversed so that bit 0 is the first CRC bit on the wire
  function automatic logic [4:0] crc5_calc(input logic [10:0] bits);
    logic [4:0] crc;
    logic [4:0] res;
    logic       fb;
    crc = 5'h1f;
    for (int i = 0; i < 11; i++) begin
      fb  = bits[i] ^ crc[4];
      crc = {crc[3:0], 1'b0};
      if (fb) crc = crc ^ CRC5_POLY;
    end
    for (int i = 0; i < 5; i++) begin
      res[i] = ~crc[4-i];
    end
    return res;
  endfunction

  // One byte of the reflected CRC16, not inverted
  function automatic logic [15:0] crc16_step(input logic [15:0] crc, input usb_byte_t data);
    logic [15:0] c;
    c = crc ^ {8'h00, data};
    for (int i = 0; i < 8; i++) begin
      if (c[0]) c = (c >> 1) ^ CRC16_POLY_R;
      else c = c >> 1;
    end
    return c;
  endfunction

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module usb_host_pkt_tx_tb -f usb_host_pkt_tx.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vusb_host_pkt_tx_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

echo "$output" | grep -qx "test passed" || exit 1
exit 0

//--- testbench/usb_host_pkt_tx_check.svh
`ifndef USB_HOST_PKT_TX_CHECK_SVH
`define USB_HOST_PKT_TX_CHECK_SVH

// PID byte carries the complement in its upper nibble
function automatic logic [7:0] pid_byte(input logic [3:0] pid);
  return {~pid, pid};
endfunction

// Token kind encoding OUT=0, SOF=1, IN=2, SETUP=3
function automatic logic [3:0] token_pid(input logic [1:0] kind);
  case (kind)
    2'd0: return 4'b0001;
    2'd1: return 4'b0101;
    2'd2: return 4'b1001;
    default: return 4'b1101;
  endcase
endfunction

// Reflected CRC5, bit 0 of the result goes out first
function automatic logic [4:0] ref_crc5(input logic [10:0] bits);
  logic [4:0] crc;
  crc = 5'h1f;
  for (int i = 0; i < 11; i++) begin
    if (crc[0] ^ bits[i]) crc = {1'b0, crc[4:1]} ^ 5'b10100;
    else crc = {1'b0, crc[4:1]};
  end
  return ~crc;
endfunction

// Bitwise reflected CRC16 over one byte, LSB first
function automatic logic [15:0] ref_crc16(input logic [15:0] crc_in, input logic [7:0] b);
  logic [15:0] crc;
  crc = crc_in;
  for (int i = 0; i < 8; i++) begin
    if (crc[0] ^ b[i]) crc = {1'b0, crc[15:1]} ^ 16'ha001;
    else crc = {1'b0, crc[15:1]};
  end
  return crc;
endfunction

function automatic int rand_val();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return {17'd0, lcg_state[30:16]};
endfunction

function automatic void refresh_head();
  exp_avail = (exp_q.size() != 0);
  if (exp_avail) exp_word = exp_q[0];
  else exp_word = 9'h000;
endfunction

byte_expected: assert property (@(negedge clock) disable iff (!rst_n_i)
  (tx_valid_o && tx_ready_i) |-> exp_avail)
else begin
  $display("Unexpected output byte %02h at %0t with nothing left to send", tx_data_o, $time);
  fail_cnt++;
end

byte_value: assert property (@(negedge clock) disable iff (!rst_n_i)
  (tx_valid_o && tx_ready_i && exp_avail) |-> (tx_data_o == exp_word[7:0]))
else begin
  $display("Mismatch at %0t: tx_data_o is %02h, expected %02h", $time, tx_data_o,
           exp_word[7:0]);
  mismatch_cnt++;
end

last_flag: assert property (@(negedge clock) disable iff (!rst_n_i)
  (tx_valid_o && tx_ready_i && exp_avail) |-> (tx_last_o == exp_word[8]))
else begin
  $display("Mismatch at %0t: tx_last_o is %0b on byte %02h, expected %0b", $time,
           tx_last_o, tx_data_o, exp_word[8]);
  mismatch_cnt++;
end

// Done may coincide with the final byte leaving, never precede it
done_after_last: assert property (@(negedge clock) disable iff (!rst_n_i)
  pkt_done_o |-> ((owed != 0) || (tx_valid_o && tx_ready_i && tx_last_o)))
else begin
  $display("pkt_done_o pulsed at %0t without a finished packet", $time);
  fail_cnt++;
end

quiet_after_reset: assert property (@(negedge clock) disable iff (!rst_n_i)
  !started |-> !(tx_valid_o || dat_ready_o || busy_o || pkt_done_o))
else begin
  $display("Outputs active at %0t before any request was made", $time);
  fail_cnt++;
end

first_byte_latency: assert property (@(negedge clock) disable iff (!rst_n_i)
  (lat_check && $past(busy_o) && !$past(busy_o, 2)) |-> tx_valid_o)
else begin
  $display("First byte late at %0t, tx_valid_o not up two cycles after the strobe", $time);
  fail_cnt++;
end

`endif

//--- testbench/usb_host_pkt_tx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module usb_host_pkt_tx_tb;

  localparam int WAIT_LIMIT = 400;

  logic                   clock;
  logic                   rst_n_i;
  logic                   tok_send_i;
  usb_pkt_pkg::tok_kind_t tok_kind_i;
  usb_pkt_pkg::usb_addr_t tok_addr_i;
  usb_pkt_pkg::usb_endp_t tok_endp_i;
  logic                   hsk_send_i;
  usb_pkt_pkg::hsk_kind_t hsk_kind_i;
  logic                   dat_send_i;
  logic                   dat_odd_i;
  logic                   dat_zero_i;
  logic                   dat_valid_i;
  usb_pkt_pkg::usb_byte_t dat_data_i;
  logic                   dat_last_i;
  logic                   dat_ready_o;
  logic                   tx_valid_o;
  usb_pkt_pkg::usb_byte_t tx_data_o;
  logic                   tx_last_o;
  logic                   tx_ready_i;
  logic                   busy_o;
  logic                   pkt_done_o;

  // Expected bytes as {last, data}
  logic [8:0]  exp_q[$];
  logic [8:0]  exp_word;
  logic        exp_avail;
  logic [7:0]  pay_buf [0:63];
  logic [31:0] lcg_state;
  logic        started;
  logic        lat_check;
  logic        jitter;
  logic        took;
  logic        took_last;
  logic        done_seen;
  int          mismatch_cnt;
  int          fail_cnt;
  int          pkt_cnt;
  int          done_cnt;
  int          owed;

  `include "usb_host_pkt_tx_check.svh"

  usb_host_pkt_tx usb_host_pkt_tx_i (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .tok_send_i  (tok_send_i),
    .tok_kind_i  (tok_kind_i),
    .tok_addr_i  (tok_addr_i),
    .tok_endp_i  (tok_endp_i),
    .hsk_send_i  (hsk_send_i),
    .hsk_kind_i  (hsk_kind_i),
    .dat_send_i  (dat_send_i),
    .dat_odd_i   (dat_odd_i),
    .dat_zero_i  (dat_zero_i),
    .dat_valid_i (dat_valid_i),
    .dat_data_i  (dat_data_i),
    .dat_last_i  (dat_last_i),
    .dat_ready_o (dat_ready_o),
    .tx_valid_o  (tx_valid_o),
    .tx_data_o   (tx_data_o),
    .tx_last_o   (tx_last_o),
    .tx_ready_i  (tx_ready_i),
    .busy_o      (busy_o),
    .pkt_done_o  (pkt_done_o)
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;

  // Transfers seen mid-cycle are retired at the next rising edge
  always @(negedge clock) begin
    took      = rst_n_i && tx_valid_o && tx_ready_i;
    took_last = took && tx_last_o;
    done_seen = rst_n_i && pkt_done_o;
  end

  always @(posedge clock) begin
    if (took && exp_q.size() != 0) void'(exp_q.pop_front());
    refresh_head();
    if (took_last) owed = owed + 1;
    if (done_seen) begin
      done_cnt = done_cnt + 1;
      owed     = owed - 1;
    end
  end

  task automatic finish_run();
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  task automatic push_byte(input logic [7:0] b, input logic last);
    exp_q.push_back({last, b});
    refresh_head();
  endtask

  // Feeds the payload and waits for the end of the packet
  task automatic run_request(input int npay);
    int   idx;
    int   guard;
    int   r;
    logic done;
    idx   = 0;
    guard = 0;
    done  = 1'b0;
    while (!done && guard < WAIT_LIMIT) begin
      @(posedge clock);
      r = rand_val();
      if (idx < npay) begin
        dat_valid_i <= jitter ? (r[0] | r[1]) : 1'b1;
        dat_data_i  <= pay_buf[idx];
        dat_last_i  <= (idx == npay - 1);
      end else begin
        dat_valid_i <= 1'b0;
        dat_last_i  <= 1'b0;
      end
      tx_ready_i <= jitter ? (r[2] | r[3]) : 1'b1;
      @(negedge clock);
      if (dat_valid_i && dat_ready_o) idx++;
      done = pkt_done_o;
      guard++;
    end
    if (!done) begin
      $display("Timeout at %0t waiting for pkt_done_o", $time);
      fail_cnt++;
      finish_run();
    end
  endtask

  task automatic send_token(input logic [1:0] kind, input logic [6:0] addr,
                            input logic [3:0] endp);
    logic [4:0] crc;
    crc = ref_crc5({endp, addr});
    push_byte(pid_byte(token_pid(kind)), 1'b0);
    push_byte({endp[0], addr}, 1'b0);
    push_byte({crc, endp[3:1]}, 1'b1);
    @(posedge clock);
    tok_send_i <= 1'b1;
    tok_kind_i <= usb_pkt_pkg::tok_kind_t'(kind);
    tok_addr_i <= addr;
    tok_endp_i <= endp;
    started    <= 1'b1;
    pkt_cnt++;
    run_request(0);
    @(posedge clock);
    tok_send_i <= 1'b0;
  endtask

  task automatic send_hsk(input logic nak);
    push_byte(pid_byte(nak ? 4'b1010 : 4'b0010), 1'b1);
    @(posedge clock);
    hsk_send_i <= 1'b1;
    hsk_kind_i <= usb_pkt_pkg::hsk_kind_t'(nak);
    started    <= 1'b1;
    pkt_cnt++;
    run_request(0);
    @(posedge clock);
    hsk_send_i <= 1'b0;
  endtask

  // Payload is random, CRC16 goes out inverted, low byte first
  task automatic send_data(input logic odd, input logic zero, input int len);
    logic [15:0] crc;
    int          r;
    crc = 16'hffff;
    push_byte(pid_byte(odd ? 4'b1011 : 4'b0011), 1'b0);
    for (int i = 0; i < len; i++) begin
      r          = rand_val();
      pay_buf[i] = r[7:0];
      push_byte(r[7:0], 1'b0);
      crc = ref_crc16(crc, r[7:0]);
    end
    push_byte(~crc[7:0], 1'b0);
    push_byte(~crc[15:8], 1'b1);
    @(posedge clock);
    dat_send_i <= 1'b1;
    dat_odd_i  <= odd;
    dat_zero_i <= zero;
    started    <= 1'b1;
    pkt_cnt++;
    run_request(len);
    @(posedge clock);
    dat_send_i <= 1'b0;
    dat_zero_i <= 1'b0;
  endtask

  task automatic run_all(input logic jit);
    int len;
    @(posedge clock);
    jitter    = jit;
    lat_check = !jit;
    send_token(2'd3, 7'h09, 4'h0);
    send_token(2'd2, 7'h09, 4'h1);
    send_token(2'd0, 7'h09, 4'h1);
    // SOF frame 123 hex, low seven bits in the address field
    send_token(2'd1, 7'h23, 4'h2);
    send_hsk(1'b0);
    send_hsk(1'b1);
    send_data(1'b0, 1'b0, 8);
    len = 1 + (rand_val() % 20);
    send_data(1'b1, 1'b0, len);
    send_data(1'b1, 1'b1, 0);
  endtask

  initial begin
    lcg_state   = 32'd61;
    rst_n_i     = 1'b0;
    tok_send_i  = 1'b0;
    tok_kind_i  = usb_pkt_pkg::TOK_OUT;
    tok_addr_i  = 7'h00;
    tok_endp_i  = 4'h0;
    hsk_send_i  = 1'b0;
    hsk_kind_i  = usb_pkt_pkg::HSK_ACK;
    dat_send_i  = 1'b0;
    dat_odd_i   = 1'b0;
    dat_zero_i  = 1'b0;
    dat_valid_i = 1'b0;
    dat_data_i  = 8'h00;
    dat_last_i  = 1'b0;
    tx_ready_i  = 1'b0;
    started     = 1'b0;
    lat_check   = 1'b0;
    jitter      = 1'b0;
    took        = 1'b0;
    took_last   = 1'b0;
    done_seen   = 1'b0;
    exp_avail   = 1'b0;
    exp_word    = 9'h000;
    repeat (16) @(posedge clock);
    rst_n_i <= 1'b1;
    repeat (4) @(posedge clock);
    run_all(1'b0);
    run_all(1'b1);
    repeat (4) @(posedge clock);
    all_bytes_sent: assert (exp_q.size() == 0)
    else begin
      $display("%0d expected bytes never left the DUT", exp_q.size());
      fail_cnt++;
    end
    done_per_packet: assert (done_cnt == pkt_cnt)
    else begin
      $display("pkt_done_o pulsed %0d times for %0d packets", done_cnt, pkt_cnt);
      fail_cnt++;
    end
    finish_run();
  end

endmodule

`default_nettype wire

//--- usb_host_pkt_tx.f
rtl/usb_pkt_pkg.sv
rtl/pkt_request_select.sv
rtl/pkt_assemble.sv
rtl/tx_byte_stage.sv
rtl/usb_host_pkt_tx.sv
testbench/usb_host_pkt_tx_tb.sv
+incdir+testbench
